// ==== vlog.f ====
common/ooo_pkg.sv
design/fu_alu.sv
design/fu_mult.sv
cdb/cdb.sv
design/phys_regfile.sv
design/complete_stage.sv
tb/complete_properties.sv
tb/complete_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the complete stage testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module complete_tb -f vlog.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vcomplete_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -q 'All tests passed!'; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== tb/complete_tb.sv ====
// complete_tb: random issue stream with rollbacks, reference model, checks, timeout
module complete_tb import ooo_pkg::*; ();

  logic clock, reset;
  logic alu_valid, mult_valid, alu_ready, mult_ready;
  alu_op_e alu_op;
  logic [data_w-1:0] alu_a, alu_b, mult_a, mult_b, complete_value, rd_value;
  logic [pr_w-1:0] alu_tag, mult_tag, complete_tag, rd_tag;
  logic [rob_w-1:0] alu_rob_idx, mult_rob_idx, rollback_idx, rob_tail, complete_rob_idx;
  logic [reg_w-1:0] alu_dest, mult_dest, complete_dest;
  logic rollback_en, complete_en;

  logic              pend_live  [num_pr];  // issued, not yet broadcast or squashed
  logic [data_w-1:0] pend_value [num_pr];
  logic [rob_w-1:0]  pend_rob   [num_pr];
  logic [reg_w-1:0]  pend_dest  [num_pr];
  int                pend_seq   [num_pr];  // issue order, oldest = rob head
  logic [data_w-1:0] rf_model   [num_pr];  // last broadcast value per tag
  logic [pr_w-1:0]   free_tags [$];
  logic [rob_w-1:0]  tail;                 // model rob tail
  int  issued, seq, cycle_limit;
  int  instr_total = 400;
  int  cycles = 0;
  int  drain_cycles = 0;
  int  alu_stalls = 0;                     // cycles with alu_ready low
  int  mult_stalls = 0;                    // cycles with mult_ready low
  bit  alu_went, mult_went;                // handshake seen this cycle

  complete_stage dut0 (.*);

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  always @(posedge clock) cycles <= cycles + 1;

  initial begin
    cycle_limit = instr_total * 10 + 200;
    wait (cycles == cycle_limit);
    abort_run("run did not finish within the cycle limit");
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [data_w-1:0] exp,
                             input logic [data_w-1:0] got);
    if (exp !== got) begin
      abort_run($sformatf("FAILED %s exp %h got %h", name, exp, got));
    end
  endtask

  function automatic logic [data_w-1:0] alu_expect(alu_op_e op, logic [data_w-1:0] a,
                                                   logic [data_w-1:0] b);
    case (op)
      op_add:  return a + b;
      op_sub:  return a - b;
      op_and:  return a & b;
      op_or:   return a | b;
      op_xor:  return a ^ b;
      op_sll:  return a << b[4:0];
      op_srl:  return a >> b[4:0];
      default: return '0;
    endcase
  endfunction

  function automatic logic [rob_w-1:0] rob_head();
    int               oldest;
    logic [rob_w-1:0] head;
    oldest = -1;
    head   = tail;  // empty window
    for (int t = 1; t < num_pr; t++) begin
      if (pend_live[t] && (oldest < 0 || pend_seq[t] < oldest)) begin
        oldest = pend_seq[t];
        head   = pend_rob[t];
      end
    end
    return head;
  endfunction

  function automatic int window_used();
    logic [rob_w-1:0] used;
    used = tail - rob_head();  // wraps modulo num_rob
    return int'(used);
  endfunction

  function automatic int pending_count();
    int n;
    n = 0;
    for (int t = 0; t < num_pr; t++) n += int'(pend_live[t]);
    return n;
  endfunction

  function automatic bit room_to_issue();
    return issued < instr_total && window_used() < 14 && free_tags.size() > 0;
  endfunction

  task automatic offer(input bit to_mult);
    logic [pr_w-1:0]   t;
    logic [data_w-1:0] a;
    logic [data_w-1:0] b;
    logic [reg_w-1:0]  d;
    alu_op_e           op;
    t  = free_tags.pop_front();
    a  = $urandom();
    b  = $urandom();
    d  = reg_w'($urandom());
    op = alu_op_e'(3'($urandom_range(0, 6)));
    pend_live[t] = 1'b1;
    pend_rob[t]  = tail;
    pend_dest[t] = d;
    pend_seq[t]  = seq;
    if (to_mult) begin
      {mult_valid, mult_a, mult_b, mult_tag, mult_rob_idx, mult_dest} = {1'b1, a, b, t, tail, d};
      pend_value[t] = a * b;  // low half of the product
    end else begin
      {alu_valid, alu_op, alu_a, alu_b} = {1'b1, op, a, b};
      {alu_tag, alu_rob_idx, alu_dest} = {t, tail, d};
      pend_value[t] = alu_expect(op, a, b);
    end
    tail = tail + 1'b1;
    seq++;
    issued++;
  endtask

  task automatic squash_model();
    for (int t = 1; t < num_pr; t++) begin
      if (pend_live[t] && rob_squashed(pend_rob[t], rollback_idx, rob_tail)) begin
        pend_live[t] = 1'b0;  // never allowed on the bus now
        free_tags.push_back(pr_w'(t));
      end
    end
  endtask

  task automatic check_broadcast();
    logic [pr_w-1:0] t;
    t = complete_tag;
    if (complete_en === 1'b1) begin
      if (!pend_live[t]) begin
        abort_run($sformatf("tag %0d broadcast with no pending instruction", t));
      end else begin
        check_value("complete_value", pend_value[t], complete_value);
        check_value("complete_rob_idx", data_w'(pend_rob[t]), data_w'(complete_rob_idx));
        check_value("complete_dest", data_w'(pend_dest[t]), data_w'(complete_dest));
        rf_model[t]  = complete_value;  // lands in the prf on this edge
        pend_live[t] = 1'b0;
        free_tags.push_back(t);
      end
    end
  endtask

  task automatic run_cycle(input bit allow_issue);
    bit do_rb;
    @(negedge clock);
    if (alu_went) alu_valid = 1'b0;    // taken on the last edge
    if (mult_went) mult_valid = 1'b0;
    rollback_en = 1'b0;
    do_rb = allow_issue && !alu_valid && !mult_valid && window_used() > 0 &&
            $urandom_range(0, 24) == 0;
    if (do_rb) begin
      rollback_en  = 1'b1;
      rollback_idx = rob_head() + rob_w'($urandom_range(0, window_used() - 1));
    end else if (allow_issue) begin
      if (!alu_valid && room_to_issue() && $urandom_range(0, 3) != 0) offer(1'b0);
      if (!mult_valid && room_to_issue() && $urandom_range(0, 3) != 0) offer(1'b1);
    end
    rob_tail = tail;
    #1;  // let ready and the broadcast settle
    alu_went  = alu_valid && alu_ready;
    mult_went = mult_valid && mult_ready;
    if (!alu_ready) alu_stalls++;
    if (!mult_ready) mult_stalls++;
    if (do_rb) squash_model();
    check_broadcast();
    if (do_rb) tail = rollback_idx;  // younger entries are gone
  endtask

  initial begin
    void'($urandom(45));
    {reset, alu_valid, mult_valid, rollback_en} = 4'b1000;
    alu_op = op_add;
    {alu_a, alu_b, mult_a, mult_b} = '0;
    {alu_tag, mult_tag, rd_tag} = '0;
    {alu_rob_idx, mult_rob_idx, rollback_idx, rob_tail} = '0;
    {alu_dest, mult_dest} = '0;
    {tail, issued, seq, alu_went, mult_went} = '0;
    for (int t = 0; t < num_pr; t++) begin
      pend_live[t] = 1'b0;
      rf_model[t]  = '0;
      if (t != 0) free_tags.push_back(pr_w'(t));  // p0 never allocated
    end
    repeat (8) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    #1;
    check_value("alu_ready", data_w'(1'b1), data_w'(alu_ready));  // both units idle
    check_value("mult_ready", data_w'(1'b1), data_w'(mult_ready));
    while (issued < instr_total) run_cycle(1'b1);
    while (pending_count() != 0 && drain_cycles < 100) begin  // drain both units
      run_cycle(1'b0);
      drain_cycles++;
    end
    if (pending_count() != 0) begin
      abort_run("instructions still pending after drain");
    end
    if (alu_stalls == 0 || mult_stalls == 0) begin
      abort_run("a ready signal never dropped under back-pressure");
    end
    repeat (10) run_cycle(1'b0);                   // bus must stay quiet
    for (int t = 0; t < num_pr; t++) begin
      @(negedge clock);
      rd_tag = pr_w'(t);
      #1;
      check_value("rd_value", rf_model[t], rd_value);
    end
    $display("All tests passed!");
    $finish;
  end

endmodule

// ==== tb/complete_properties.sv ====
// complete_properties: concurrent checks on cdb broadcast and slot free flags, bind to cdb
module complete_properties import ooo_pkg::*; (
  input logic                        clock,
  input logic                        reset,
  input logic [num_fu-1:0]           taken,     // slot occupied
  input logic [num_fu-1:0][pr_w-1:0] slot_tag,  // tag held per slot
  input logic [num_fu-1:0]           free,
  input logic                        rollback_en,
  input logic                        complete_en,
  input logic [pr_w-1:0]             complete_tag
);

  a_quiet_after_reset: assert property (@(posedge clock) reset |=> !complete_en)
    else $error("broadcast in the cycle after reset");

  for (genvar i = 0; i < num_fu; i++) begin : g_slot
    // a held slot frees only while its own tag is on the bus
    a_hold_until_sent: assert property (@(posedge clock) disable iff (reset)
      taken[i] && free[i] && !rollback_en |-> complete_en && complete_tag == slot_tag[i])
      else $error("slot %0d reported free before its result was broadcast", i);
  end

  a_no_tag_zero: assert property (@(posedge clock) disable iff (reset)
    complete_en |-> complete_tag != '0)
    else $error("broadcast carried physical tag 0");

endmodule

bind cdb complete_properties props0 (
  .clock(clock), .reset(reset), .taken(taken), .slot_tag(slot_tag), .free(free),
  .rollback_en(rollback_en), .complete_en(complete_en), .complete_tag(complete_tag)
);

// ==== design/complete_stage.sv ====
// complete_stage: alu, multiplier, cdb and physical register file wiring
module complete_stage import ooo_pkg::*; (
  input  logic              clock,
  input  logic              reset,
  input  logic              alu_valid,
  input  alu_op_e           alu_op,
  input  logic [data_w-1:0] alu_a,
  input  logic [data_w-1:0] alu_b,
  input  logic [pr_w-1:0]   alu_tag,
  input  logic [rob_w-1:0]  alu_rob_idx,
  input  logic [reg_w-1:0]  alu_dest,
  input  logic              mult_valid,
  input  logic [data_w-1:0] mult_a,
  input  logic [data_w-1:0] mult_b,
  input  logic [pr_w-1:0]   mult_tag,
  input  logic [rob_w-1:0]  mult_rob_idx,
  input  logic [reg_w-1:0]  mult_dest,
  input  logic              rollback_en,
  input  logic [rob_w-1:0]  rollback_idx,
  input  logic [rob_w-1:0]  rob_tail,
  input  logic [pr_w-1:0]   rd_tag,
  output logic              alu_ready,
  output logic              mult_ready,
  output logic              complete_en,
  output logic [pr_w-1:0]   complete_tag,
  output logic [rob_w-1:0]  complete_rob_idx,
  output logic [reg_w-1:0]  complete_dest,
  output logic [data_w-1:0] complete_value,
  output logic [data_w-1:0] rd_value
);

  logic [num_fu-1:0]             fu_done;
  logic [num_fu-1:0][pr_w-1:0]   fu_tag;
  logic [num_fu-1:0][rob_w-1:0]  fu_rob_idx;
  logic [num_fu-1:0][reg_w-1:0]  fu_dest;
  logic [num_fu-1:0][data_w-1:0] fu_result;
  logic [num_fu-1:0]             fu_free;

  fu_alu alu0 (  // slot 0
    .clock, .reset,
    .issue_valid(alu_valid), .op(alu_op), .a(alu_a), .b(alu_b),
    .tag(alu_tag), .rob_idx(alu_rob_idx), .dest(alu_dest),
    .rollback_en, .rollback_idx, .rob_tail,
    .free(fu_free[0]), .issue_ready(alu_ready), .done(fu_done[0]),
    .out_tag(fu_tag[0]), .out_rob_idx(fu_rob_idx[0]), .out_dest(fu_dest[0]),
    .result(fu_result[0])
  );

  fu_mult mult0 (  // slot 1
    .clock, .reset,
    .issue_valid(mult_valid), .a(mult_a), .b(mult_b),
    .tag(mult_tag), .rob_idx(mult_rob_idx), .dest(mult_dest),
    .rollback_en, .rollback_idx, .rob_tail,
    .free(fu_free[1]), .issue_ready(mult_ready), .done(fu_done[1]),
    .out_tag(fu_tag[1]), .out_rob_idx(fu_rob_idx[1]), .out_dest(fu_dest[1]),
    .result(fu_result[1])
  );

  cdb cdb0 (
    .clock, .reset,
    .fu_done, .fu_tag, .fu_rob_idx, .fu_dest, .fu_result,
    .rollback_en, .rollback_idx, .rob_tail,
    .free(fu_free),
    .complete_en, .complete_tag, .complete_rob_idx, .complete_dest, .complete_value
  );

  phys_regfile prf0 (  // written straight from the broadcast
    .clock, .reset,
    .write_en(complete_en), .write_tag(complete_tag), .write_value(complete_value),
    .rd_tag, .rd_value
  );

endmodule

// ==== design/phys_regfile.sv ====
// phys_regfile: 32-entry physical register file, cdb write port, async read
module phys_regfile import ooo_pkg::*; (
  input  logic              clock,
  input  logic              reset,
  input  logic              write_en,
  input  logic [pr_w-1:0]   write_tag,
  input  logic [data_w-1:0] write_value,
  input  logic [pr_w-1:0]   rd_tag,
  output logic [data_w-1:0] rd_value
);

  logic [data_w-1:0] regs [num_pr];
  logic              wr_ok;

  assign wr_ok = write_en && (write_tag != '0);  // p0 stays zero

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < num_pr; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_ok) begin
      regs[write_tag] <= write_value;
    end
  end

  // combinational read, no bypass of a same-cycle write
  assign rd_value = (rd_tag == '0) ? '0 : regs[rd_tag];

endmodule

// ==== cdb/cdb.sv ====
// cdb: per-unit result slots, rollback squash, priority broadcast, free flags
module cdb import ooo_pkg::*; (
  input  logic                          clock,
  input  logic                          reset,
  input  logic [num_fu-1:0]             fu_done,
  input  logic [num_fu-1:0][pr_w-1:0]   fu_tag,
  input  logic [num_fu-1:0][rob_w-1:0]  fu_rob_idx,
  input  logic [num_fu-1:0][reg_w-1:0]  fu_dest,
  input  logic [num_fu-1:0][data_w-1:0] fu_result,
  input  logic                          rollback_en,
  input  logic [rob_w-1:0]              rollback_idx,
  input  logic [rob_w-1:0]              rob_tail,
  output logic [num_fu-1:0]             free,
  output logic                          complete_en,
  output logic [pr_w-1:0]               complete_tag,
  output logic [rob_w-1:0]              complete_rob_idx,
  output logic [reg_w-1:0]              complete_dest,
  output logic [data_w-1:0]             complete_value
);

  logic [num_fu-1:0]             taken, taken_n;
  logic [num_fu-1:0][pr_w-1:0]   slot_tag, slot_tag_n;
  logic [num_fu-1:0][rob_w-1:0]  slot_rob, slot_rob_n;
  logic [num_fu-1:0][reg_w-1:0]  slot_dest, slot_dest_n;
  logic [num_fu-1:0][data_w-1:0] slot_value, slot_value_n;
  logic [num_fu-1:0]             live;    // held and surviving rollback
  logic [num_fu-1:0]             bc_sel;  // one-hot broadcast slot
  logic [num_fu-1:0]             fu_dead; // unit output squashed now

  always_comb begin
    for (int i = 0; i < num_fu; i++) begin
      live[i]    = taken[i] &&
                   !(rollback_en && rob_squashed(slot_rob[i], rollback_idx, rob_tail));
      fu_dead[i] = rollback_en && rob_squashed(fu_rob_idx[i], rollback_idx, rob_tail);
    end
  end

  // broadcast from registered slots, lowest index wins
  always_comb begin
    complete_en      = 1'b0;
    complete_tag     = '0;
    complete_rob_idx = '0;
    complete_dest    = '0;
    complete_value   = '0;
    bc_sel           = '0;
    for (int i = 0; i < num_fu; i++) begin
      if (live[i] && !complete_en) begin
        complete_en      = 1'b1;
        complete_tag     = slot_tag[i];
        complete_rob_idx = slot_rob[i];
        complete_dest    = slot_dest[i];
        complete_value   = slot_value[i];
        bc_sel[i]        = 1'b1;
      end
    end
  end

  always_comb begin
    taken_n      = taken;
    slot_tag_n   = slot_tag;
    slot_rob_n   = slot_rob;
    slot_dest_n  = slot_dest;
    slot_value_n = slot_value;
    for (int i = 0; i < num_fu; i++) begin
      if (!taken[i] && fu_done[i]) begin  // capture into empty slot
        taken_n[i]      = 1'b1;
        slot_tag_n[i]   = fu_tag[i];
        slot_rob_n[i]   = fu_rob_idx[i];
        slot_dest_n[i]  = fu_dest[i];
        slot_value_n[i] = fu_result[i];
      end
    end
    if (rollback_en) begin
      for (int i = 0; i < num_fu; i++) begin
        if (rob_squashed(slot_rob_n[i], rollback_idx, rob_tail)) begin
          taken_n[i] = 1'b0;  // younger than the rollback point
        end
      end
    end
    for (int i = 0; i < num_fu; i++) begin
      if (bc_sel[i]) begin
        // same tag means the unit still shows what we just sent
        if (fu_done[i] && fu_tag[i] != slot_tag[i] && !fu_dead[i]) begin
          slot_tag_n[i]   = fu_tag[i];
          slot_rob_n[i]   = fu_rob_idx[i];
          slot_dest_n[i]  = fu_dest[i];
          slot_value_n[i] = fu_result[i];
        end else begin
          taken_n[i] = 1'b0;
        end
      end
    end
    free = ~taken_n;  // unit may move on once its slot drains
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      taken <= '0;
    end else begin
      taken <= taken_n;
    end
  end

  always_ff @(posedge clock) begin
    slot_tag   <= slot_tag_n;
    slot_rob   <= slot_rob_n;
    slot_dest  <= slot_dest_n;
    slot_value <= slot_value_n;
  end

endmodule

// ==== design/fu_mult.sv ====
// fu_mult: three-stage pipelined multiplier with cdb back-pressure stall
module fu_mult import ooo_pkg::*; (
  input  logic             clock,
  input  logic             reset,
  input  logic             issue_valid,
  input  logic [data_w-1:0] a,
  input  logic [data_w-1:0] b,
  input  logic [pr_w-1:0]  tag,
  input  logic [rob_w-1:0] rob_idx,
  input  logic [reg_w-1:0] dest,
  input  logic             rollback_en,
  input  logic [rob_w-1:0] rollback_idx,
  input  logic [rob_w-1:0] rob_tail,
  input  logic             free,
  output logic             issue_ready,
  output logic             done,
  output logic [pr_w-1:0]  out_tag,
  output logic [rob_w-1:0] out_rob_idx,
  output logic [reg_w-1:0] out_dest,
  output logic [data_w-1:0] result
);

  logic [2:0]             stage_valid;
  logic [2:0][pr_w-1:0]   stage_tag;
  logic [2:0][rob_w-1:0]  stage_rob;
  logic [2:0][reg_w-1:0]  stage_dest;
  logic [2:0][data_w-1:0] stage_prod;   // low product only
  logic [2:0]             stage_squash;
  logic                   squash_in;
  logic                   stall;

  assign stall       = stage_valid[2] && !free;  // last stage blocked
  assign issue_ready = !stall;
  assign squash_in   = rollback_en && rob_squashed(rob_idx, rollback_idx, rob_tail);

  always_comb begin
    for (int s = 0; s < 3; s++) begin
      stage_squash[s] = rollback_en && rob_squashed(stage_rob[s], rollback_idx, rob_tail);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      stage_valid <= '0;
    end else if (stall) begin
      stage_valid <= stage_valid & ~stage_squash;  // frozen, but still squash
    end else begin
      stage_valid[0] <= issue_valid && !squash_in;
      stage_valid[1] <= stage_valid[0] && !stage_squash[0];
      stage_valid[2] <= stage_valid[1] && !stage_squash[1];
    end
  end

  always_ff @(posedge clock) begin
    if (!stall) begin
      stage_tag[0]  <= tag;
      stage_rob[0]  <= rob_idx;
      stage_dest[0] <= dest;
      stage_prod[0] <= a * b;  // 32-bit context keeps low half
      for (int s = 1; s < 3; s++) begin
        stage_tag[s]  <= stage_tag[s-1];
        stage_rob[s]  <= stage_rob[s-1];
        stage_dest[s] <= stage_dest[s-1];
        stage_prod[s] <= stage_prod[s-1];
      end
    end
  end

  assign done        = stage_valid[2];
  assign out_tag     = stage_tag[2];
  assign out_rob_idx = stage_rob[2];
  assign out_dest    = stage_dest[2];
  assign result      = stage_prod[2];

endmodule

// ==== design/fu_alu.sv ====
// fu_alu: single-cycle integer alu with held output register
module fu_alu import ooo_pkg::*; (
  input  logic             clock,
  input  logic             reset,
  input  logic             issue_valid,
  input  alu_op_e          op,
  input  logic [data_w-1:0] a,
  input  logic [data_w-1:0] b,
  input  logic [pr_w-1:0]  tag,
  input  logic [rob_w-1:0] rob_idx,
  input  logic [reg_w-1:0] dest,
  input  logic             rollback_en,
  input  logic [rob_w-1:0] rollback_idx,
  input  logic [rob_w-1:0] rob_tail,
  input  logic             free,         // cdb slot empty next cycle
  output logic             issue_ready,
  output logic             done,
  output logic [pr_w-1:0]  out_tag,
  output logic [rob_w-1:0] out_rob_idx,
  output logic [reg_w-1:0] out_dest,
  output logic [data_w-1:0] result
);

  logic [data_w-1:0] alu_out;
  logic              accept;
  logic              squash_in;   // incoming op already dead
  logic              squash_held; // held result killed by rollback

  assign issue_ready = !done || free;  // output reg drains when slot frees
  assign accept      = issue_valid && issue_ready;
  assign squash_in   = rollback_en && rob_squashed(rob_idx, rollback_idx, rob_tail);
  assign squash_held = rollback_en && rob_squashed(out_rob_idx, rollback_idx, rob_tail);

  always_comb begin
    case (op)
      op_add:  alu_out = a + b;
      op_sub:  alu_out = a - b;
      op_and:  alu_out = a & b;
      op_or:   alu_out = a | b;
      op_xor:  alu_out = a ^ b;
      op_sll:  alu_out = a << b[4:0];
      op_srl:  alu_out = a >> b[4:0];  // logical
      default: alu_out = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      done <= 1'b0;
    end else if (accept) begin
      done <= !squash_in;
    end else if (free || squash_held) begin
      done <= 1'b0;  // taken by cdb or squashed
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin  // payload only moves on handshake
      out_tag     <= tag;
      out_rob_idx <= rob_idx;
      out_dest    <= dest;
      result      <= alu_out;
    end
  end

endmodule

// ==== common/ooo_pkg.sv ====
// ooo_pkg: core sizes, alu opcode enum, rollback age function
package ooo_pkg;

  localparam int num_fu  = 2;   // slot 0 alu, slot 1 mult
  localparam int num_rob = 16;  // reorder buffer entries
  localparam int rob_w   = 4;   // rob index width
  localparam int num_pr  = 32;  // physical registers
  localparam int pr_w    = 5;   // physical tag width
  localparam int data_w  = 32;  // result width
  localparam int reg_w   = 5;   // architectural register index

  // alu opcodes, shifts take b[4:0]
  typedef enum logic [2:0] {
    op_add = 3'd0,
    op_sub = 3'd1,
    op_and = 3'd2,
    op_or  = 3'd3,
    op_xor = 3'd4,
    op_sll = 3'd5,
    op_srl = 3'd6
  } alu_op_e;

  // true when entry sits at or after the rollback point in the rob window.
  // both distances are taken from the rollback index modulo num_rob, so the
  // window wraps cleanly around the end of the rob
  function automatic logic rob_squashed(
    input logic [rob_w-1:0] entry,
    input logic [rob_w-1:0] rollback,
    input logic [rob_w-1:0] tail
  );
    logic [rob_w-1:0] dist_tail;
    logic [rob_w-1:0] dist_entry;
    dist_tail  = tail - rollback;   // wraps modulo num_rob
    dist_entry = entry - rollback;  // wraps modulo num_rob
    return (dist_tail >= dist_entry);
  endfunction

endpackage
